// File: rob_pkg.sv
// widths assume 64-bit pcs with 32 architectural and 64 physical registers, and any depth must be a power of two
package rob_pkg;

	// default entries per thread, kept a power of two
	localparam int ROB_DEPTH = 16;

	typedef logic [63:0] pc_t;	// instruction or branch target pc
	typedef logic [4:0] arn_t;	// architectural register number
	typedef logic [5:0] prn_t;	// physical register number, 64-entry prf

	// payload written at dispatch, 76 bits
	typedef struct packed
	{
		pc_t pc;
		arn_t arn;
		prn_t prn;
		logic is_branch;
	} rob_entry_t;

	// arn shown on a commit slot with nothing to commit
	localparam arn_t ZERO_REG = 5'd31;

endpackage

// File: rob_entry_array.sv
// one dispatch write per index per cycle is assumed, and a dispatch write beats a completion to the same index
module rob_entry_array #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic wr_en1,
	input logic wr_en2,
	input logic [$clog2(DEPTH)-1:0] wr_idx1,
	input logic [$clog2(DEPTH)-1:0] wr_idx2,
	input rob_pkg::rob_entry_t wr_entry1,
	input rob_pkg::rob_entry_t wr_entry2,
	input logic cpl_en,
	input logic [$clog2(DEPTH)-1:0] cpl_idx,
	input logic cpl_mispredict,
	input rob_pkg::pc_t cpl_target,
	input logic [$clog2(DEPTH)-1:0] rd_idx0,
	input logic [$clog2(DEPTH)-1:0] rd_idx1,
	output rob_pkg::rob_entry_t rd_entry0,
	output rob_pkg::rob_entry_t rd_entry1,
	output logic rd_done0,
	output logic rd_done1,
	output logic rd_mispredict0,
	output logic rd_mispredict1,
	output rob_pkg::pc_t rd_target0,
	output rob_pkg::pc_t rd_target1
);
	import rob_pkg::*;

	rob_entry_t entry_mem [DEPTH];	// pc, arn, prn, is_branch per slot
	pc_t target_mem [DEPTH];	// resolved target from the fu
	logic [DEPTH-1:0] mispredict_mem;
	logic [DEPTH-1:0] done_q;	// set by completion, cleared by dispatch

	// payload and completion data
	always_ff @(posedge clock)
	begin
		if (wr_en1)
			entry_mem[wr_idx1] <= wr_entry1;
		if (wr_en2)
			entry_mem[wr_idx2] <= wr_entry2;
		if (cpl_en)
		begin
			mispredict_mem[cpl_idx] <= cpl_mispredict;
			target_mem[cpl_idx] <= cpl_target;
		end
	end

	// done flags, the only control state here
	always_ff @(posedge clock)
	begin
		if (reset)
			done_q <= '0;
		else
		begin
			if (cpl_en)
				done_q[cpl_idx] <= 1'b1;
			// later statements win, so a fresh dispatch drops a stale completion
			if (wr_en1)
				done_q[wr_idx1] <= 1'b0;
			if (wr_en2)
				done_q[wr_idx2] <= 1'b0;
		end
	end

	// head and head+1 reads, combinational
	assign rd_entry0 = entry_mem[rd_idx0];
	assign rd_entry1 = entry_mem[rd_idx1];
	assign rd_done0 = done_q[rd_idx0];
	assign rd_done1 = done_q[rd_idx1];
	assign rd_mispredict0 = mispredict_mem[rd_idx0];
	assign rd_mispredict1 = mispredict_mem[rd_idx1];
	assign rd_target0 = target_mem[rd_idx0];
	assign rd_target1 = target_mem[rd_idx1];

endmodule

// File: rob_thread_queue.sv
// DEPTH must be a power of two, and pushes must stay within the credits the dispatcher holds
module rob_thread_queue #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic [1:0] push_count,	// 0 to 2 new entries at the tail
	input rob_pkg::rob_entry_t push_entry1,
	input rob_pkg::rob_entry_t push_entry2,
	input logic cpl_en,
	input logic [$clog2(DEPTH)-1:0] cpl_idx,
	input logic cpl_mispredict,
	input rob_pkg::pc_t cpl_target,
	input logic [1:0] pop_count,	// 0 to 2 entries leaving the head
	input logic squash,
	output logic [$clog2(DEPTH)-1:0] tail_idx,
	output rob_pkg::rob_entry_t head_entry0,
	output logic head_done0,
	output logic head_mispredict0,
	output rob_pkg::pc_t head_target0,
	output rob_pkg::rob_entry_t head_entry1,
	output logic head_done1,
	output logic head_mispredict1,
	output rob_pkg::pc_t head_target1,
	output logic [$clog2(DEPTH):0] count,
	output logic [$clog2(DEPTH):0] credit_return
);
	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = IDX_W + 1;	// holds 0 to DEPTH

	logic [IDX_W-1:0] head;
	logic [IDX_W-1:0] tail;
	logic [IDX_W-1:0] head_next;	// head after this cycle's commits
	logic [IDX_W-1:0] head_plus1;
	logic [IDX_W-1:0] tail_plus1;
	logic wr_en1;
	logic wr_en2;

	assign head_next = head + IDX_W'(pop_count);
	assign head_plus1 = head + 1'b1;	// wraps at DEPTH
	assign tail_plus1 = tail + 1'b1;
	assign tail_idx = tail;

	// a squash drops whatever is dispatched in the same cycle
	assign wr_en1 = (push_count != 2'd0) && !squash;
	assign wr_en2 = (push_count == 2'd2) && !squash;

	// pointers and occupancy
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= head_next;
			if (squash)
			begin
				tail <= head_next;	// everything behind the branch is gone
				count <= '0;
			end
			else
			begin
				tail <= tail + IDX_W'(push_count);
				count <= count + CNT_W'(push_count) - CNT_W'(pop_count);
			end
		end
	end

	// commits, plus on squash the discarded entries and the dropped push
	assign credit_return = squash ? count + CNT_W'(push_count) : CNT_W'(pop_count);

	rob_entry_array #(
		.DEPTH(DEPTH)
	) i_entries (
		.clock(clock),
		.reset(reset),
		.wr_en1(wr_en1),
		.wr_en2(wr_en2),
		.wr_idx1(tail),
		.wr_idx2(tail_plus1),
		.wr_entry1(push_entry1),
		.wr_entry2(push_entry2),
		.cpl_en(cpl_en),
		.cpl_idx(cpl_idx),
		.cpl_mispredict(cpl_mispredict),
		.cpl_target(cpl_target),
		.rd_idx0(head),
		.rd_idx1(head_plus1),
		.rd_entry0(head_entry0),
		.rd_entry1(head_entry1),
		.rd_done0(head_done0),
		.rd_done1(head_done1),
		.rd_mispredict0(head_mispredict0),
		.rd_mispredict1(head_mispredict1),
		.rd_target0(head_target0),
		.rd_target1(head_target1)
	);

endmodule

// File: rob_writeback_route.sv
// fu1 wins on equal tags, and a waiting fu2 result is lost if both units complete into its thread again before it drains
module rob_writeback_route #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic fu1_done,
	input logic [$clog2(DEPTH):0] fu1_tag,	// msb set means thread 2
	input logic fu1_mispredict,
	input rob_pkg::pc_t fu1_target_pc,
	input logic fu2_done,
	input logic [$clog2(DEPTH):0] fu2_tag,
	input logic fu2_mispredict,
	input rob_pkg::pc_t fu2_target_pc,
	output logic t1_cpl_en,
	output logic [$clog2(DEPTH)-1:0] t1_cpl_idx,
	output logic t1_cpl_mispredict,
	output rob_pkg::pc_t t1_cpl_target,
	output logic t2_cpl_en,
	output logic [$clog2(DEPTH)-1:0] t2_cpl_idx,
	output logic t2_cpl_mispredict,
	output rob_pkg::pc_t t2_cpl_target
);
	import rob_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);

	logic fu2_live;	// fu2 result not shadowed by fu1
	logic fu2_sent;
	logic fu2_wait;	// fu2 lost its thread port this cycle
	logic hold_drain;
	logic hold_valid;
	logic [IDX_W:0] hold_tag;
	logic hold_mispredict;
	pc_t hold_target;
	logic port_en [2];	// index 0 is thread 1
	logic [IDX_W-1:0] port_idx [2];
	logic port_mispredict [2];
	pc_t port_target [2];

	assign fu2_live = fu2_done && !(fu1_done && fu1_tag == fu2_tag);

	// one completion port per thread, fu1 then the held result then fu2
	always_comb
	begin
		hold_drain = 1'b0;
		fu2_sent = 1'b0;
		for (int t = 0; t < 2; t++)
		begin
			port_en[t] = 1'b0;
			port_idx[t] = '0;
			port_mispredict[t] = 1'b0;
			port_target[t] = '0;
			if (fu1_done && fu1_tag[IDX_W] == 1'(t))
			begin
				port_en[t] = 1'b1;
				port_idx[t] = fu1_tag[IDX_W-1:0];
				port_mispredict[t] = fu1_mispredict;
				port_target[t] = fu1_target_pc;
			end
			else if (hold_valid && hold_tag[IDX_W] == 1'(t))
			begin
				port_en[t] = 1'b1;
				port_idx[t] = hold_tag[IDX_W-1:0];
				port_mispredict[t] = hold_mispredict;
				port_target[t] = hold_target;
				hold_drain = 1'b1;
			end
			else if (fu2_live && fu2_tag[IDX_W] == 1'(t))
			begin
				port_en[t] = 1'b1;
				port_idx[t] = fu2_tag[IDX_W-1:0];
				port_mispredict[t] = fu2_mispredict;
				port_target[t] = fu2_target_pc;
				fu2_sent = 1'b1;
			end
		end
	end

	assign fu2_wait = fu2_live && !fu2_sent;

	always_ff @(posedge clock)
	begin
		if (reset)
			hold_valid <= 1'b0;
		else if (fu2_wait)
			hold_valid <= 1'b1;
		else if (hold_drain)
			hold_valid <= 1'b0;
	end

	// held fu2 payload, written out one edge later
	always_ff @(posedge clock)
	begin
		if (fu2_wait)
		begin
			hold_tag <= fu2_tag;
			hold_mispredict <= fu2_mispredict;
			hold_target <= fu2_target_pc;
		end
	end

	assign t1_cpl_en = port_en[0];
	assign t1_cpl_idx = port_idx[0];
	assign t1_cpl_mispredict = port_mispredict[0];
	assign t1_cpl_target = port_target[0];
	assign t2_cpl_en = port_en[1];
	assign t2_cpl_idx = port_idx[1];
	assign t2_cpl_mispredict = port_mispredict[1];
	assign t2_cpl_target = port_target[1];

endmodule

// File: rob_commit_select.sv
// commit has no back-pressure, and squash only flags the thread since its queue discards the younger entries
module rob_commit_select #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH
) (
	input rob_pkg::rob_entry_t t1_entry0,
	input logic t1_done0,
	input logic t1_mispredict0,
	input rob_pkg::pc_t t1_target0,
	input rob_pkg::rob_entry_t t1_entry1,
	input logic t1_done1,
	input logic t1_mispredict1,
	input rob_pkg::pc_t t1_target1,
	input logic [$clog2(DEPTH):0] t1_count,
	input rob_pkg::rob_entry_t t2_entry0,
	input logic t2_done0,
	input logic t2_mispredict0,
	input rob_pkg::pc_t t2_target0,
	input rob_pkg::rob_entry_t t2_entry1,
	input logic t2_done1,
	input logic t2_mispredict1,
	input rob_pkg::pc_t t2_target1,
	input logic [$clog2(DEPTH):0] t2_count,
	output logic [1:0] t1_pop,
	output logic [1:0] t2_pop,
	output logic t1_squash,
	output logic t2_squash,
	output logic commit1_valid,
	output rob_pkg::pc_t commit1_pc,
	output rob_pkg::pc_t commit1_target_pc,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output rob_pkg::arn_t commit1_arn,
	output rob_pkg::prn_t commit1_prn,
	output logic commit1_is_thread1,
	output logic commit2_valid,
	output rob_pkg::pc_t commit2_pc,
	output rob_pkg::pc_t commit2_target_pc,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output rob_pkg::arn_t commit2_arn,
	output rob_pkg::prn_t commit2_prn,
	output logic commit2_is_thread1
);
	import rob_pkg::*;

	// candidates indexed by thread bit then position, so 2 is the thread-2 head
	rob_entry_t cand_entry [4];
	pc_t cand_target [4];
	logic [3:0] cand_mispredict;
	logic [3:0] cand_ready;	// occupied and done
	logic [3:0] cand_flush;	// mispredicted branch
	logic sel1_valid;
	logic sel2_valid;
	logic [1:0] sel1;
	logic [1:0] sel2;

	always_comb
	begin
		cand_entry = '{t1_entry0, t1_entry1, t2_entry0, t2_entry1};
		cand_target = '{t1_target0, t1_target1, t2_target0, t2_target1};
		cand_mispredict = {t2_mispredict1, t2_mispredict0, t1_mispredict1, t1_mispredict0};
		cand_ready[0] = (t1_count != '0) && t1_done0;
		cand_ready[1] = (t1_count > 1) && t1_done1;	// head+1 must be occupied too
		cand_ready[2] = (t2_count != '0) && t2_done0;
		cand_ready[3] = (t2_count > 1) && t2_done1;
		for (int i = 0; i < 4; i++)
			cand_flush[i] = cand_entry[i].is_branch && cand_mispredict[i];
	end

	// slot 1 prefers thread 1, slot 2 stays in-thread unless that is blocked
	always_comb
	begin
		sel1_valid = 1'b1;
		sel1 = 2'd0;
		sel2_valid = 1'b0;
		sel2 = 2'd0;
		if (cand_ready[0])
			sel1 = 2'd0;
		else if (cand_ready[2])
			sel1 = 2'd2;
		else
			sel1_valid = 1'b0;
		if (sel1_valid && cand_ready[sel1 | 2'd1] && !cand_flush[sel1])
		begin
			sel2_valid = 1'b1;
			sel2 = sel1 | 2'd1;
		end
		else if (sel1_valid && sel1 == 2'd0 && cand_ready[2])
		begin
			sel2_valid = 1'b1;	// other thread may still go after a thread-1 squash
			sel2 = 2'd2;
		end
	end

	assign t1_pop = {1'b0, sel1_valid & ~sel1[1]} + {1'b0, sel2_valid & ~sel2[1]};
	assign t2_pop = {1'b0, sel1_valid & sel1[1]} + {1'b0, sel2_valid & sel2[1]};
	assign t1_squash = (sel1_valid && !sel1[1] && cand_flush[sel1])
		|| (sel2_valid && !sel2[1] && cand_flush[sel2]);
	assign t2_squash = (sel1_valid && sel1[1] && cand_flush[sel1])
		|| (sel2_valid && sel2[1] && cand_flush[sel2]);

	// idle slots show zeros and ZERO_REG
	assign commit1_valid = sel1_valid;
	assign commit1_pc = sel1_valid ? cand_entry[sel1].pc : '0;
	assign commit1_target_pc = sel1_valid ? cand_target[sel1] : '0;
	assign commit1_is_branch = sel1_valid && cand_entry[sel1].is_branch;
	assign commit1_mispredict = sel1_valid && cand_mispredict[sel1];
	assign commit1_arn = sel1_valid ? cand_entry[sel1].arn : ZERO_REG;
	assign commit1_prn = sel1_valid ? cand_entry[sel1].prn : '0;
	assign commit1_is_thread1 = sel1_valid && !sel1[1];

	assign commit2_valid = sel2_valid;
	assign commit2_pc = sel2_valid ? cand_entry[sel2].pc : '0;
	assign commit2_target_pc = sel2_valid ? cand_target[sel2] : '0;
	assign commit2_is_branch = sel2_valid && cand_entry[sel2].is_branch;
	assign commit2_mispredict = sel2_valid && cand_mispredict[sel2];
	assign commit2_arn = sel2_valid ? cand_entry[sel2].arn : ZERO_REG;
	assign commit2_prn = sel2_valid ? cand_entry[sel2].prn : '0;
	assign commit2_is_thread1 = sel2_valid && !sel2[1];

endmodule

// File: rob.sv
// dispatch_thread 1 selects thread 2, and a dispatch into a thread squashing that cycle is dropped with its credits returned
module rob #(
	parameter int DEPTH = rob_pkg::ROB_DEPTH
) (
	input logic clock,
	input logic reset,
	input logic inst1_valid,
	input rob_pkg::pc_t inst1_pc,
	input rob_pkg::arn_t inst1_arn,
	input rob_pkg::prn_t inst1_prn,
	input logic inst1_is_branch,
	input logic inst2_valid,
	input rob_pkg::pc_t inst2_pc,
	input rob_pkg::arn_t inst2_arn,
	input rob_pkg::prn_t inst2_prn,
	input logic inst2_is_branch,
	input logic dispatch_thread,	// same for both instructions
	output logic [$clog2(DEPTH):0] inst1_tag,
	output logic [$clog2(DEPTH):0] inst2_tag,
	input logic fu1_done,
	input logic [$clog2(DEPTH):0] fu1_tag,
	input logic fu1_mispredict,
	input rob_pkg::pc_t fu1_target_pc,
	input logic fu2_done,
	input logic [$clog2(DEPTH):0] fu2_tag,
	input logic fu2_mispredict,
	input rob_pkg::pc_t fu2_target_pc,
	output logic commit1_valid,
	output rob_pkg::pc_t commit1_pc,
	output rob_pkg::pc_t commit1_target_pc,
	output logic commit1_is_branch,
	output logic commit1_mispredict,
	output rob_pkg::arn_t commit1_arn,
	output rob_pkg::prn_t commit1_prn,
	output logic commit1_is_thread1,
	output logic commit2_valid,
	output rob_pkg::pc_t commit2_pc,
	output rob_pkg::pc_t commit2_target_pc,
	output logic commit2_is_branch,
	output logic commit2_mispredict,
	output rob_pkg::arn_t commit2_arn,
	output rob_pkg::prn_t commit2_prn,
	output logic commit2_is_thread1,
	output logic [$clog2(DEPTH):0] t1_credit_return,
	output logic [$clog2(DEPTH):0] t2_credit_return
);
	import rob_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);

	rob_entry_t inst1_entry, inst2_entry, push_entry1;
	logic [1:0] push_count, t1_push, t2_push;
	logic [IDX_W-1:0] t1_tail, t2_tail, disp_tail, disp_tail1;
	rob_entry_t t1_entry0, t1_entry1, t2_entry0, t2_entry1;
	logic t1_done0, t1_done1, t2_done0, t2_done1;
	logic t1_mispredict0, t1_mispredict1, t2_mispredict0, t2_mispredict1;
	pc_t t1_target0, t1_target1, t2_target0, t2_target1;
	logic [IDX_W:0] t1_count, t2_count;
	logic [1:0] t1_pop, t2_pop;
	logic t1_squash, t2_squash;
	logic t1_cpl_en, t2_cpl_en;
	logic [IDX_W-1:0] t1_cpl_idx, t2_cpl_idx;
	logic t1_cpl_mispredict, t2_cpl_mispredict;
	pc_t t1_cpl_target, t2_cpl_target;

	assign inst1_entry = '{pc: inst1_pc, arn: inst1_arn, prn: inst1_prn, is_branch: inst1_is_branch};
	assign inst2_entry = '{pc: inst2_pc, arn: inst2_arn, prn: inst2_prn, is_branch: inst2_is_branch};
	assign push_entry1 = inst1_valid ? inst1_entry : inst2_entry;	// lone inst2 takes the tail slot
	assign push_count = {1'b0, inst1_valid} + {1'b0, inst2_valid};
	assign t1_push = dispatch_thread ? 2'd0 : push_count;
	assign t2_push = dispatch_thread ? push_count : 2'd0;

	// tags are thread bit over the tail index
	assign disp_tail = dispatch_thread ? t2_tail : t1_tail;
	assign disp_tail1 = disp_tail + 1'b1;
	assign inst1_tag = {dispatch_thread, disp_tail};
	assign inst2_tag = {dispatch_thread, inst1_valid ? disp_tail1 : disp_tail};

	rob_thread_queue #(.DEPTH(DEPTH)) i_t1_queue (
		.clock(clock), .reset(reset),
		.push_count(t1_push), .push_entry1(push_entry1), .push_entry2(inst2_entry),
		.cpl_en(t1_cpl_en), .cpl_idx(t1_cpl_idx),
		.cpl_mispredict(t1_cpl_mispredict), .cpl_target(t1_cpl_target),
		.pop_count(t1_pop), .squash(t1_squash), .tail_idx(t1_tail),
		.head_entry0(t1_entry0), .head_done0(t1_done0),
		.head_mispredict0(t1_mispredict0), .head_target0(t1_target0),
		.head_entry1(t1_entry1), .head_done1(t1_done1),
		.head_mispredict1(t1_mispredict1), .head_target1(t1_target1),
		.count(t1_count), .credit_return(t1_credit_return)
	);

	rob_thread_queue #(.DEPTH(DEPTH)) i_t2_queue (
		.clock(clock), .reset(reset),
		.push_count(t2_push), .push_entry1(push_entry1), .push_entry2(inst2_entry),
		.cpl_en(t2_cpl_en), .cpl_idx(t2_cpl_idx),
		.cpl_mispredict(t2_cpl_mispredict), .cpl_target(t2_cpl_target),
		.pop_count(t2_pop), .squash(t2_squash), .tail_idx(t2_tail),
		.head_entry0(t2_entry0), .head_done0(t2_done0),
		.head_mispredict0(t2_mispredict0), .head_target0(t2_target0),
		.head_entry1(t2_entry1), .head_done1(t2_done1),
		.head_mispredict1(t2_mispredict1), .head_target1(t2_target1),
		.count(t2_count), .credit_return(t2_credit_return)
	);

	// port names match the local nets one to one
	rob_writeback_route #(.DEPTH(DEPTH)) i_route (.*);

	rob_commit_select #(.DEPTH(DEPTH)) i_select (.*);

endmodule

// File: rob_tb.sv
// DEPTH 16 only; fu1 and fu2 always hit different threads, so the fu2 hold register stays idle
module rob_tb;
	import rob_pkg::*;

	localparam int DEPTH = 16;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int N_DIRECTED = 33;
	localparam int N_ROWS = N_DIRECTED + 200;

	logic clock;
	logic reset;
	logic inst1_valid, inst2_valid, inst1_is_branch, inst2_is_branch, dispatch_thread;
	pc_t inst1_pc, inst2_pc;
	arn_t inst1_arn, inst2_arn;
	prn_t inst1_prn, inst2_prn;
	logic [IDX_W:0] inst1_tag, inst2_tag, fu1_tag, fu2_tag;
	logic fu1_done, fu1_mispredict, fu2_done, fu2_mispredict;
	pc_t fu1_target_pc, fu2_target_pc;
	logic commit1_valid, commit1_is_branch, commit1_mispredict, commit1_is_thread1;
	logic commit2_valid, commit2_is_branch, commit2_mispredict, commit2_is_thread1;
	pc_t commit1_pc, commit1_target_pc, commit2_pc, commit2_target_pc;
	arn_t commit1_arn, commit2_arn;
	prn_t commit1_prn, commit2_prn;
	logic [IDX_W:0] t1_credit_return, t2_credit_return;

	// stimulus table, one row per cycle; completions pick the k-th pending entry of a thread
	int row_n [N_ROWS];	// instructions offered, 0 to 2
	logic row_thr [N_ROWS];
	logic row_br [N_ROWS];
	logic row_c1 [N_ROWS];
	logic row_c1thr [N_ROWS];	// fu2 takes the other thread
	int row_p1 [N_ROWS];
	logic row_m1 [N_ROWS];
	logic row_c2 [N_ROWS];
	int row_p2 [N_ROWS];
	logic row_m2 [N_ROWS];

	// reference model of both queues
	rob_entry_t m_entry [2][DEPTH];
	logic m_done [2][DEPTH];
	logic m_misp [2][DEPTH];
	pc_t m_target [2][DEPTH];
	int m_head [2];
	int m_tail [2];
	int m_count [2];
	int credits [2];	// dispatcher side, starts at DEPTH

	// this cycle's decisions and expected results
	logic sel_valid [2];
	int sel_thr [2];
	int sel_pos [2];
	int pop [2];
	logic sq [2];
	int ret [2];
	int req_n;
	int req_thr;
	logic req_lone2;	// a single request rides on inst2
	rob_entry_t new_e [2];
	logic c_en [2];	// index is the fu
	int c_thr [2];
	int c_idx [2];
	logic c_misp [2];
	pc_t c_tgt [2];
	integer seed;

	rob #(.DEPTH(DEPTH)) i_rob (.*);

	initial
		clock = 1'b0;
	always #10 clock = ~clock;

	initial
	begin
		#((N_ROWS + 50) * 20);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired before all rows were applied");
	end

	task automatic stop_run(string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "check failed");
	endtask

	task automatic check_pc(string name, pc_t exp, pc_t act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_arn(string name, arn_t exp, arn_t act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_prn(string name, prn_t exp, prn_t act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_tag(string name, logic [IDX_W:0] exp, logic [IDX_W:0] act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_credit(string name, logic [IDX_W:0] exp, logic [IDX_W:0] act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp)
			stop_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
	endtask

	task automatic set_row(int r, int n, int thr, int br, int c1, int c1thr, int p1, int m1,
		int c2, int p2);
		row_n[r] = n;
		row_thr[r] = thr[0];
		row_br[r] = br[0];
		row_c1[r] = c1[0];
		row_c1thr[r] = c1thr[0];
		row_p1[r] = p1;
		row_m1[r] = m1[0];
		row_c2[r] = c2[0];
		row_p2[r] = p2;
		row_m2[r] = 1'b0;
	endtask

	task automatic fill_table();
		set_row(0, 2, 0, 0, 0, 0, 0, 0, 0, 0);	// first pair, tags 0 and 1
		set_row(1, 2, 0, 1, 0, 0, 0, 0, 0, 0);	// two branches behind it
		set_row(2, 0, 0, 0, 1, 0, 3, 0, 0, 0);	// youngest completes first
		set_row(3, 0, 0, 0, 1, 0, 1, 0, 0, 0);
		set_row(4, 0, 0, 0, 1, 0, 0, 0, 0, 0);
		set_row(5, 0, 0, 0, 1, 0, 0, 1, 0, 0);	// entry 2 resolves mispredicted
		set_row(6, 2, 0, 0, 0, 0, 0, 0, 0, 0);	// squash cycle, dispatch dropped
		set_row(7, 2, 0, 0, 0, 0, 0, 0, 0, 0);	// tags resume after the branch
		for (int r = 8; r < 17; r++)
			set_row(r, 2, 1, 0, 0, 0, 0, 0, 0, 0);	// fill thread 2, last row has no credits
		for (int r = 17; r < N_DIRECTED; r++)
			set_row(r, 0, 0, 0, 0, 0, 0, 0, 1, r * 7);	// drain thread 2, thread 1 stalled
		for (int r = N_DIRECTED; r < N_ROWS; r++)
		begin
			row_n[r] = $random(seed) & 3;
			if (row_n[r] == 3)
				row_n[r] = 2;
			row_thr[r] = $random(seed) & 1;
			row_br[r] = ($random(seed) & 3) == 0;
			row_c1[r] = ($random(seed) & 3) != 0;
			row_c1thr[r] = $random(seed) & 1;
			row_p1[r] = $random(seed) & 15;
			row_m1[r] = $random(seed) & 1;
			row_c2[r] = ($random(seed) & 3) != 0;
			row_p2[r] = $random(seed) & 15;
			row_m2[r] = $random(seed) & 1;
		end
	endtask

	function automatic logic is_flush(int t, int pos);
		int idx;
		idx = (m_head[t] + pos) % DEPTH;
		return m_entry[t][idx].is_branch && m_misp[t][idx];
	endfunction

	// k-th not yet completed entry of a thread, oldest first, or -1
	function automatic int find_pending(int t, int pick);
		int nd;
		int k;
		int idx;
		nd = 0;
		for (int i = 0; i < m_count[t]; i++)
			if (!m_done[t][(m_head[t] + i) % DEPTH])
				nd++;
		if (nd == 0)
			return -1;
		k = pick % nd;
		for (int i = 0; i < m_count[t]; i++)
		begin
			idx = (m_head[t] + i) % DEPTH;
			if (!m_done[t][idx])
			begin
				if (k == 0)
					return idx;
				k--;
			end
		end
		return -1;
	endfunction

	// slot 1 prefers thread 1, slot 2 stays in-thread unless blocked
	task automatic select_commits();
		logic rdy [2][2];
		for (int t = 0; t < 2; t++)
		begin
			rdy[t][0] = m_count[t] > 0 && m_done[t][m_head[t]];
			rdy[t][1] = m_count[t] > 1 && m_done[t][(m_head[t] + 1) % DEPTH];
			pop[t] = 0;
			sq[t] = 1'b0;
			sel_valid[t] = 1'b0;
		end
		if (rdy[0][0] || rdy[1][0])
		begin
			sel_valid[0] = 1'b1;
			sel_thr[0] = rdy[0][0] ? 0 : 1;
			sel_pos[0] = 0;
			if (rdy[sel_thr[0]][1] && !is_flush(sel_thr[0], 0))
			begin
				sel_valid[1] = 1'b1;
				sel_thr[1] = sel_thr[0];
				sel_pos[1] = 1;
			end
			else if (sel_thr[0] == 0 && rdy[1][0])
			begin
				sel_valid[1] = 1'b1;
				sel_thr[1] = 1;
				sel_pos[1] = 0;
			end
		end
		for (int s = 0; s < 2; s++)
			if (sel_valid[s])
			begin
				pop[sel_thr[s]]++;
				if (is_flush(sel_thr[s], sel_pos[s]))
					sq[sel_thr[s]] = 1'b1;
			end
	endtask

	task automatic plan_row(int r);
		select_commits();
		req_thr = row_thr[r];
		req_n = row_n[r] > credits[req_thr] ? credits[req_thr] : row_n[r];	// credit gating
		req_lone2 = req_n == 1 && ($random(seed) & 1);	// lone request sometimes on inst2
		for (int k = 0; k < 2; k++)
			new_e[k] = '{pc: {$random(seed), $random(seed)}, arn: $random(seed),
				prn: $random(seed), is_branch: row_br[r]};
		for (int t = 0; t < 2; t++)
			ret[t] = sq[t] ? m_count[t] + (req_thr == t ? req_n : 0) : pop[t];
		c_thr[0] = row_c1thr[r];
		c_thr[1] = !row_c1thr[r];
		for (int f = 0; f < 2; f++)
		begin
			c_idx[f] = find_pending(c_thr[f], f == 0 ? row_p1[r] : row_p2[r]);
			c_en[f] = (f == 0 ? row_c1[r] : row_c2[r]) && c_idx[f] >= 0;
			c_misp[f] = c_en[f] && (f == 0 ? row_m1[r] : row_m2[r])
				&& m_entry[c_thr[f]][c_idx[f]].is_branch;	// only branches mispredict
			c_tgt[f] = {$random(seed), $random(seed)};
		end
		inst1_valid <= req_n == 2 || (req_n == 1 && !req_lone2);
		inst2_valid <= req_n == 2 || req_lone2;
		dispatch_thread <= req_thr[0];
		{inst1_pc, inst1_arn, inst1_prn, inst1_is_branch} <= new_e[0];
		{inst2_pc, inst2_arn, inst2_prn, inst2_is_branch} <= new_e[1];
		fu1_done <= c_en[0];
		fu1_tag <= {c_thr[0][0], IDX_W'(c_idx[0])};
		fu1_mispredict <= c_misp[0];
		fu1_target_pc <= c_tgt[0];
		fu2_done <= c_en[1];
		fu2_tag <= {c_thr[1][0], IDX_W'(c_idx[1])};
		fu2_mispredict <= c_misp[1];
		fu2_target_pc <= c_tgt[1];
	endtask

	// mirrors the clock edge for the decisions of the previous row
	task automatic update_model();
		int head_new;
		for (int f = 0; f < 2; f++)
			if (c_en[f])
			begin
				m_done[c_thr[f]][c_idx[f]] = 1'b1;
				m_misp[c_thr[f]][c_idx[f]] = c_misp[f];
				m_target[c_thr[f]][c_idx[f]] = c_tgt[f];
			end
		for (int t = 0; t < 2; t++)
		begin
			head_new = (m_head[t] + pop[t]) % DEPTH;
			if (sq[t])
			begin
				m_tail[t] = head_new;	// younger entries and this cycle's dispatch dropped
				m_count[t] = 0;
			end
			else
			begin
				if (req_thr == t)
					for (int k = 0; k < req_n; k++)
					begin
						m_entry[t][(m_tail[t] + k) % DEPTH] = req_lone2 ? new_e[1] : new_e[k];
						m_done[t][(m_tail[t] + k) % DEPTH] = 1'b0;
					end
				m_count[t] = m_count[t] + (req_thr == t ? req_n : 0) - pop[t];
				m_tail[t] = (m_tail[t] + (req_thr == t ? req_n : 0)) % DEPTH;
			end
			m_head[t] = head_new;
			credits[t] = credits[t] - (req_thr == t ? req_n : 0) + ret[t];
		end
	endtask

	task automatic check_slot(int r, int s, logic valid, pc_t pc, pc_t tgt, logic br, logic mp,
		arn_t arn, prn_t prn, logic th1);
		string tn;
		rob_entry_t e;
		int idx;
		tn = $sformatf("row %0d commit%0d", r, s + 1);
		e = '{pc: '0, arn: ZERO_REG, prn: '0, is_branch: 1'b0};	// idle slot view
		idx = 0;
		if (sel_valid[s])
		begin
			idx = (m_head[sel_thr[s]] + sel_pos[s]) % DEPTH;
			e = m_entry[sel_thr[s]][idx];
		end
		check_flag({tn, " valid"}, sel_valid[s], valid);
		check_pc({tn, " pc"}, e.pc, pc);
		check_pc({tn, " target_pc"}, sel_valid[s] ? m_target[sel_thr[s]][idx] : '0, tgt);
		check_flag({tn, " is_branch"}, e.is_branch, br);
		check_flag({tn, " mispredict"}, sel_valid[s] && m_misp[sel_thr[s]][idx], mp);
		check_arn({tn, " arn"}, e.arn, arn);
		check_prn({tn, " prn"}, e.prn, prn);
		check_flag({tn, " is_thread1"}, sel_valid[s] && sel_thr[s] == 0, th1);
	endtask

	task automatic check_row(int r);
		logic [IDX_W-1:0] tail;
		tail = IDX_W'(m_tail[req_thr]);
		check_slot(r, 0, commit1_valid, commit1_pc, commit1_target_pc, commit1_is_branch,
			commit1_mispredict, commit1_arn, commit1_prn, commit1_is_thread1);
		check_slot(r, 1, commit2_valid, commit2_pc, commit2_target_pc, commit2_is_branch,
			commit2_mispredict, commit2_arn, commit2_prn, commit2_is_thread1);
		check_credit($sformatf("row %0d t1 credit", r), ret[0], t1_credit_return);
		check_credit($sformatf("row %0d t2 credit", r), ret[1], t2_credit_return);
		if (req_n >= 1 && !req_lone2 && !sq[req_thr])	// tags are meaningless in a squash cycle
			check_tag($sformatf("row %0d inst1 tag", r), {req_thr[0], tail}, inst1_tag);
		if (req_n == 2 && !sq[req_thr])
			check_tag($sformatf("row %0d inst2 tag", r), {req_thr[0], tail + 1'b1}, inst2_tag);
		if (req_lone2 && !sq[req_thr])	// lone inst2 takes the tail slot
			check_tag($sformatf("row %0d inst2 tag", r), {req_thr[0], tail}, inst2_tag);
	endtask

	initial
	begin
		seed = 32'h962c;
		reset = 1'b1;
		{inst1_valid, inst2_valid, inst1_is_branch, inst2_is_branch, dispatch_thread} = '0;
		{inst1_pc, inst2_pc, inst1_arn, inst2_arn, inst1_prn, inst2_prn} = '0;
		{fu1_done, fu1_tag, fu1_mispredict, fu1_target_pc} = '0;
		{fu2_done, fu2_tag, fu2_mispredict, fu2_target_pc} = '0;
		fill_table();
		for (int t = 0; t < 2; t++)
		begin
			m_head[t] = 0;
			m_tail[t] = 0;
			m_count[t] = 0;
			credits[t] = DEPTH;
			pop[t] = 0;
			sq[t] = 1'b0;
			ret[t] = 0;
			c_en[t] = 1'b0;
			for (int i = 0; i < DEPTH; i++)
				m_done[t][i] = 1'b0;
		end
		req_n = 0;
		req_thr = 0;
		req_lone2 = 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		for (int r = 0; r < N_ROWS; r++)
		begin
			@(posedge clock);
			update_model();
			plan_row(r);
			@(negedge clock);	// combinational outputs settled
			check_row(r);
		end
		$display("TESTS PASSED");
		$finish;
	end

endmodule

// File: rob.f
rob_pkg.sv
rob_entry_array.sv
rob_thread_queue.sv
rob_writeback_route.sv
rob_commit_select.sv
rob.sv
rob_tb.sv
